//--- Bender.yml
package:
  name: dataL1

export_include_dirs:
  - .

sources:
  - cachePkg.sv
  - tagStore.sv
  - dataStore.sv
  - mainMemory.sv
  - cacheController.sv
  - dataL1.sv
  - target: test
    files:
      - tbDataL1.sv

//--- cacheController.sv
// Cache FSM: lookup, dirty write-back, refill and CPU response under req/ack handshakes
`include "dataL1_defs.svh"

module cacheController
    import cachePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    // CPU side
    input  cpuReqT cpuReq,
    input  logic   cpuReqValid,
    output cpuRspT cpuRsp,
    output logic   cpuAck,
    // Tag store
    output indexT  tagIndex,
    input  tagT    storedTag,
    input  logic   storedValid,
    input  logic   storedDirty,
    output logic   tagWrite,
    output tagT    newTag,
    output logic   newDirty,
    // Data store
    output indexT  lineIndex,
    output offsetT wordOffset,
    output logic   lineWrite,
    output wordT   lineWdata,
    input  wordT   lineRdata,
    // Main memory
    output memReqT memReq,
    output logic   memReqValid,
    input  wordT   memRdata,
    input  logic   memAck
);

    ctrlStateE state;
    ctrlStateE nextState;

    // Latched request and response
    cpuReqT reqQ;
    wordT   rdataQ;
    logic   hitQ;

    // Word counter for line transfers
    offsetT wordCnt;

    logic hit;
    logic isWrite;
    logic memDone;
    logic memRelease;
    logic lastWord;

    // Hit needs a valid line with a matching tag
    assign hit     = storedValid && (storedTag == reqQ.addr.tag);
    assign isWrite = (reqQ.op == opWrite);

    // Word accepted by memory, then both handshake lines low again
    assign memDone    = memReqValid && memAck;
    assign memRelease = !memReqValid && !memAck;
    assign lastWord   = (wordCnt == offsetT'(`DL1_WORDS_PER_LINE - 1));

    // Next state
    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (cpuReqValid) begin
                    nextState = stLookup;
                end
            end
            stLookup: begin
                if (hit) begin
                    nextState = stRespond;
                end else if (storedValid && storedDirty) begin
                    nextState = stWriteBack;
                end else begin
                    nextState = stRefill;
                end
            end
            stWriteBack: begin
                if (memRelease && lastWord) begin
                    nextState = stRefill;
                end
            end
            stRefill: begin
                if (memRelease && lastWord) begin
                    nextState = stUpdate;
                end
            end
            stUpdate: nextState = stRespond;
            // Hold the response until the CPU drops its request
            stRespond: begin
                if (!cpuReqValid) begin
                    nextState = stIdle;
                end
            end
            default: nextState = stIdle;
        endcase
    end

    // State, memory request and word counter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= stIdle;
            memReqValid <= 1'b0;
            wordCnt     <= '0;
        end else begin
            state <= nextState;
            case (state)
                stLookup: begin
                    // Miss starts the first transfer at word 0
                    if (!hit) begin
                        memReqValid <= 1'b1;
                        wordCnt     <= '0;
                    end
                end
                stWriteBack, stRefill: begin
                    if (memDone) begin
                        memReqValid <= 1'b0;
                    end else if (memRelease) begin
                        if (lastWord) begin
                            // Write-back flows straight into refill
                            wordCnt     <= '0;
                            memReqValid <= (state == stWriteBack);
                        end else begin
                            wordCnt     <= wordCnt + 1'b1;
                            memReqValid <= 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Request capture and response data
    always_ff @(posedge clk) begin
        if (state == stIdle && cpuReqValid) begin
            reqQ <= cpuReq;
        end
        if (state == stLookup) begin
            hitQ <= hit;
        end
        // Read word taken on a hit or after the refill
        if ((state == stLookup && hit) || state == stUpdate) begin
            rdataQ <= lineRdata;
        end
    end

    // Both stores follow the latched index
    assign tagIndex  = reqQ.addr.index;
    assign lineIndex = reqQ.addr.index;

    // Line transfers walk the counter, otherwise the CPU offset
    assign wordOffset = (state == stWriteBack || state == stRefill) ? wordCnt
                                                                    : reqQ.addr.offset;

    // Write hit in lookup, or finishing the access after a refill
    assign tagWrite = (state == stLookup && hit && isWrite) || (state == stUpdate);
    assign newTag   = reqQ.addr.tag;
    assign newDirty = isWrite;

    // Refill words as memory acks them, CPU word otherwise
    assign lineWrite = (state == stRefill && memDone)
                    || (state == stLookup && hit && isWrite)
                    || (state == stUpdate && isWrite);
    assign lineWdata = (state == stRefill) ? memRdata : reqQ.wdata;

    // Victim address on write-back, requested line on refill
    always_comb begin
        memReq.write       = (state == stWriteBack);
        memReq.addr.tag    = (state == stWriteBack) ? storedTag : reqQ.addr.tag;
        memReq.addr.index  = reqQ.addr.index;
        memReq.addr.offset = wordCnt;
        memReq.wdata       = lineRdata;
    end

    assign cpuAck = (state == stRespond);
    assign cpuRsp = '{rdata: rdataQ, hit: hitQ};

    // Ack only while the CPU still holds its request
    assertAckNeedsReq: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(cpuAck) |-> cpuReqValid
    );

    // Memory request held until memory answers
    assertMemReqStable: assert property (
        @(posedge clk) disable iff (!rstN)
        (memReqValid && !memAck) |=> $stable(memReq)
    );

endmodule

//--- cachePkg.sv
// Shared cache types and request/response structs, imported by the cache RTL
`include "dataL1_defs.svh"

package cachePkg;

    // Basic fields
    typedef logic [`DL1_WORD_W-1:0]   wordT;
    typedef logic [`DL1_TAG_W-1:0]    tagT;
    typedef logic [`DL1_INDEX_W-1:0]  indexT;
    typedef logic [`DL1_OFFSET_W-1:0] offsetT;

    // Word address split, tag on top and offset at the bottom
    typedef struct packed {
        tagT    tag;
        indexT  index;
        offsetT offset;
    } addrT;

    // CPU opcode
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } cacheOpE;

    // CPU request, held stable while cpuReqValid is high
    typedef struct packed {
        cacheOpE op;
        addrT    addr;
        wordT    wdata;
    } cpuReqT;

    // CPU response, valid while cpuAck is high
    typedef struct packed {
        wordT rdata;
        logic hit;
    } cpuRspT;

    // One-word transfer to main memory
    typedef struct packed {
        logic write;
        addrT addr;
        wordT wdata;
    } memReqT;

    // Controller FSM states
    typedef enum logic [2:0] {
        stIdle, stLookup, stWriteBack, stRefill, stUpdate, stRespond
    } ctrlStateE;

endpackage

//--- dataL1.sv
// Top level of the L1 data cache: controller, tag store, line store and backing memory
module dataL1
    import cachePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  cpuReqT cpuReq,
    input  logic   cpuReqValid,
    output cpuRspT cpuRsp,
    output logic   cpuAck
);

    // Tag store wires
    indexT tagIndex;
    tagT   storedTag;
    logic  storedValid;
    logic  storedDirty;
    logic  tagWrite;
    tagT   newTag;
    logic  newDirty;

    // Line store wires
    indexT  lineIndex;
    offsetT wordOffset;
    logic   lineWrite;
    wordT   lineWdata;
    wordT   lineRdata;

    // Memory handshake
    memReqT memReq;
    logic   memReqValid;
    wordT   memRdata;
    logic   memAck;

    cacheController ctrl_i (
        .clk, .rstN,
        .cpuReq, .cpuReqValid, .cpuRsp, .cpuAck,
        .tagIndex, .storedTag, .storedValid, .storedDirty,
        .tagWrite, .newTag, .newDirty,
        .lineIndex, .wordOffset, .lineWrite, .lineWdata, .lineRdata,
        .memReq, .memReqValid, .memRdata, .memAck
    );

    tagStore tags_i (
        .clk, .rstN, .tagIndex, .tagWrite, .newTag, .newDirty,
        .storedTag, .storedValid, .storedDirty
    );

    dataStore lines_i (
        .clk, .lineIndex, .wordOffset, .lineWrite, .lineWdata, .lineRdata
    );

    mainMemory mem_i (
        .clk, .rstN, .memReq, .memReqValid, .memRdata, .memAck
    );

endmodule

//--- dataL1_defs.svh
// Geometry macros for the L1 data cache, included by the package, RTL and testbench
`ifndef DATAL1_DEFS_SVH
`define DATAL1_DEFS_SVH

// Data word width in bits
`define DL1_WORD_W 16

// Word address width, one address per 16-bit word
`define DL1_ADDR_W 16

// Word offset inside a line
`define DL1_OFFSET_W 3

// Words held by one line
`define DL1_WORDS_PER_LINE 8

// Line index width and line count
`define DL1_INDEX_W 11
`define DL1_LINES 2048

// Tag bits above the index
`define DL1_TAG_W 2

// Backing memory depth in words
`define DL1_MEM_DEPTH 65536

`endif

//--- dataStore.sv
// Cache line array with one word-wide port, addressed by line index and word offset
`include "dataL1_defs.svh"

module dataStore
    import cachePkg::*;
(
    input  logic   clk,
    input  indexT  lineIndex,
    input  offsetT wordOffset,
    input  logic   lineWrite,
    input  wordT   lineWdata,
    output wordT   lineRdata
);

    // 2048 lines of 8 words
    wordT lineArray [`DL1_LINES][`DL1_WORDS_PER_LINE];

    // One word per clock
    // refill, write hit and write miss all land here
    always_ff @(posedge clk) begin
        if (lineWrite) begin
            lineArray[lineIndex][wordOffset] <= lineWdata;
        end
    end

    // Addressed word, combinational
    // Feeds the read response and the write-back data
    assign lineRdata = lineArray[lineIndex][wordOffset];

endmodule

//--- mainMemory.sv
// Backing word memory for the cache, one word per four-phase req/ack transfer
`include "dataL1_defs.svh"

module mainMemory
    import cachePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  memReqT memReq,
    input  logic   memReqValid,
    output wordT   memRdata,
    output logic   memAck
);

    // Full word space, zero at start of simulation
    wordT memArray [`DL1_MEM_DEPTH] = '{default: '0};

    // Flat word address
    logic [`DL1_ADDR_W-1:0] memAddr;

    // New request seen, not yet acknowledged
    logic reqStart;

    assign memAddr  = memReq.addr;
    assign reqStart = memReqValid && !memAck;

    // Ack follows req by one cycle in both directions
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memAck <= 1'b0;
        end else if (reqStart) begin
            memAck <= 1'b1;
        end else if (!memReqValid && memAck) begin
            memAck <= 1'b0;
        end
    end

    // Access happens at the edge that raises memAck
    always_ff @(posedge clk) begin
        if (reqStart) begin
            if (memReq.write) begin
                memArray[memAddr] <= memReq.wdata;
            end else begin
                // Read word held until the next read
                memRdata <= memArray[memAddr];
            end
        end
    end

    // Requester keeps its request up until the ack arrives
    assertReqHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        (memReqValid && !memAck) |=> memReqValid
    );

    // Next request only once the previous ack has fallen
    assertReqAfterRelease: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(memReqValid) |-> !memAck
    );

endmodule

//--- sources.f
+incdir+.
cachePkg.sv
tagStore.sv
dataStore.sv
mainMemory.sv
cacheController.sv
dataL1.sv
tbDataL1.sv

//--- tagStore.sv
// Tag, valid and dirty bits per cache line, read combinationally and written on the clock
`include "dataL1_defs.svh"

module tagStore
    import cachePkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  indexT tagIndex,
    input  logic  tagWrite,
    input  tagT   newTag,
    input  logic  newDirty,
    output tagT   storedTag,
    output logic  storedValid,
    output logic  storedDirty
);

    // Tag array, meaningless until the valid bit is set
    tagT tagArray [`DL1_LINES];

    // Status bits, one per line
    logic [`DL1_LINES-1:0] validBits;
    logic [`DL1_LINES-1:0] dirtyBits;

    // Tag written together with the status bits
    always_ff @(posedge clk) begin
        if (tagWrite) begin
            tagArray[tagIndex] <= newTag;
        end
    end

    // Every line starts invalid and clean
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (tagWrite) begin
            // A fill or a write always leaves the line valid
            validBits[tagIndex] <= 1'b1;
            dirtyBits[tagIndex] <= newDirty;
        end
    end

    // Lookup of the addressed line
    assign storedTag   = tagArray[tagIndex];
    assign storedValid = validBits[tagIndex];
    assign storedDirty = dirtyBits[tagIndex];

endmodule

//--- tbDataL1.sv
// Self-checking random testbench for the L1 data cache, run with tbDataL1 as top module
`include "dataL1_defs.svh"

module tbDataL1
    import cachePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Run length
    localparam int NumRandomTxn = 400;
    localparam int NumDirectedTxn = 6;
    // Dirty miss moves two lines at 4 cycles per word, plus lookup, response and gaps
    localparam int CyclesPerTxn = 100;
    localparam int MaxCycles = (NumRandomTxn + NumDirectedTxn) * CyclesPerTxn + 20;

    logic   clk;
    logic   rstN;
    cpuReqT cpuReq;
    logic   cpuReqValid;
    cpuRspT cpuRsp;
    logic   cpuAck;

    // Reference model: architectural word values
    wordT memModel [`DL1_MEM_DEPTH];
    // Reference model: per-line tag, valid and dirty
    tagT  modelTag   [`DL1_LINES];
    logic modelValid [`DL1_LINES];
    logic modelDirty [`DL1_LINES];

    int errorCount;
    int cycleCount;
    int txnCount;
    int hitCount;
    int dirtyEvictions;
    logic prevAck;

    dataL1 dut_i (
        .clk, .rstN, .cpuReq, .cpuReqValid, .cpuRsp, .cpuAck
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout after %0d cycles, %0d transactions done", cycleCount, txnCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Handshake order, sampled mid-cycle
    always @(negedge clk) begin
        if (!rstN && cpuAck) begin
            $display("ERROR cpuAck during reset: expected %h, got %h", 1'b0, cpuAck);
            errorCount++;
        end
        if (rstN && prevAck && !cpuAck && cpuReqValid) begin
            $display("cpuAck fell while cpuReqValid was still high");
            errorCount++;
        end
        if (rstN && !prevAck && cpuAck && !cpuReqValid) begin
            $display("cpuAck rose without cpuReqValid");
            errorCount++;
        end
        prevAck = cpuAck;
    end

    function automatic addrT makeAddr(input int tag, input int index, input int offset);
        addrT a;
        a.tag    = tagT'(tag);
        a.index  = indexT'(index);
        a.offset = offsetT'(offset);
        return a;
    endfunction

    // One full four-phase CPU transaction, checked against the model
    task automatic runTransaction(input cacheOpE op, input addrT addr, input wordT wdata);
        int   waitCycles;
        int   holdCycles;
        logic expHit;
        wordT expData;
        expHit  = modelValid[addr.index] && (modelTag[addr.index] == addr.tag);
        expData = memModel[addr];
        holdCycles = $urandom_range(2, 0);

        @(posedge clk);
        cpuReq      <= '{op: op, addr: addr, wdata: wdata};
        cpuReqValid <= 1'b1;

        // Count rising edges from the one that samples the request
        waitCycles = 0;
        @(negedge clk);
        while (!cpuAck) begin
            @(negedge clk);
            waitCycles++;
        end

        if (cpuRsp.hit !== expHit) begin
            $display("ERROR cpuRsp.hit addr %h: expected %h, got %h", addr, expHit, cpuRsp.hit);
            errorCount++;
        end
        if (op == opRead && cpuRsp.rdata !== expData) begin
            $display("ERROR cpuRsp.rdata addr %h: expected %h, got %h",
                     addr, expData, cpuRsp.rdata);
            errorCount++;
        end
        if (expHit && waitCycles != 2) begin
            $display("Hit at address %h acknowledged after %0d edges instead of 2",
                     addr, waitCycles);
            errorCount++;
        end

        // Model follows the hit rule, refill on every miss
        if (expHit) begin
            hitCount++;
        end else begin
            if (modelValid[addr.index] && modelDirty[addr.index]) begin
                dirtyEvictions++;
            end
            modelTag[addr.index]   = addr.tag;
            modelValid[addr.index] = 1'b1;
            modelDirty[addr.index] = 1'b0;
        end
        if (op == opWrite) begin
            memModel[addr]         = wdata;
            modelDirty[addr.index] = 1'b1;
        end

        // CPU holds its request a little, ack must stay up
        repeat (holdCycles) @(posedge clk);
        @(posedge clk);
        cpuReqValid <= 1'b0;
        do begin
            @(negedge clk);
        end while (cpuAck);
        txnCount++;
    endtask

    initial begin
        cacheOpE op;
        addrT    addr;
        wordT    wdata;
        int      gap;

        void'($urandom(68));
        errorCount     = 0;
        cycleCount     = 0;
        txnCount       = 0;
        hitCount       = 0;
        dirtyEvictions = 0;
        prevAck        = 1'b0;
        rstN           = 1'b0;
        cpuReqValid    = 1'b0;
        cpuReq         = '0;
        for (int i = 0; i < `DL1_MEM_DEPTH; i++) begin
            memModel[i] = '0;
        end
        for (int i = 0; i < `DL1_LINES; i++) begin
            modelTag[i]   = '0;
            modelValid[i] = 1'b0;
            modelDirty[i] = 1'b0;
        end

        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        if (cpuAck !== 1'b0) begin
            $display("ERROR cpuAck after reset: expected %h, got %h", 1'b0, cpuAck);
            errorCount++;
        end

        // Write hit leaves neighbours alone, dirty eviction then read back
        runTransaction(opWrite, makeAddr(0, 8, 2), 16'hA5A5);
        runTransaction(opRead, makeAddr(0, 8, 2), '0);
        runTransaction(opWrite, makeAddr(0, 8, 3), 16'h1234);
        runTransaction(opRead, makeAddr(0, 8, 4), '0);
        runTransaction(opRead, makeAddr(1, 8, 2), '0);
        runTransaction(opRead, makeAddr(0, 8, 2), '0);

        // All 4 tags on 4 lines, so conflicts are frequent
        for (int n = 0; n < NumRandomTxn; n++) begin
            op    = ($urandom_range(1, 0) == 1) ? opWrite : opRead;
            addr  = makeAddr($urandom_range(3, 0), $urandom_range(3, 0), $urandom_range(7, 0));
            wdata = wordT'($urandom);
            runTransaction(op, addr, wdata);
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
        end

        $display("Transactions %0d, hits %0d, dirty evictions %0d",
                 txnCount, hitCount, dirtyEvictions);
        $display("Done after %0d cycles with %0d errors", cycleCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
